/* vlog.f */
lsu_pkg.sv
lsu_req_align.sv
lsu_bus_master.sv
lsu_load_extend.sv
lsu_data_ram.sv
lsu_top.sv
lsu_assertions.sv
tb_lsu.sv

/* run.sh */
#!/bin/sh
# build and run the load/store unit testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --assert --timing --top-module tb_lsu -f vlog.f -o sim_lsu \
  && ./obj_dir/sim_lsu > sim.log 2>&1

# the verdict comes from the log, not the exit status
grep -qF '** PASS **' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

/* tb_lsu.sv */
// directed testbench for lsu_top; the RAM is written in full before any partial access is checked
module tb_lsu;

  localparam int N_FILL     = 256;
  localparam int N_FIRST    = 2;
  localparam int N_PARTIAL  = 28;                   // 14 stores, each followed by a load
  localparam int N_EXTEND   = 58;                   // two patterns, 1 store and 28 loads each
  localparam int N_MISALIGN = 45;
  localparam int N_RANDOM   = 200;
  localparam int REQ_COUNT  = N_FIRST + N_FILL + N_PARTIAL + N_EXTEND + N_MISALIGN + N_RANDOM;
  localparam int CYCLE_LIMIT = 20 * REQ_COUNT + 100;

  logic                clk;
  logic                arst_n_i;
  logic                req_valid_i;
  lsu_pkg::mem_req_t   req_i;
  logic                busy_o;
  logic                done_o;
  logic                err_o;
  logic [63:0]         rdata_o;

  logic [63:0] shadow [256];  // reference copy of the RAM
  logic [63:0] rng;
  logic [63:0] last_rdata;
  int          cycle_cnt = 0;

  lsu_top dut (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .err_o       (err_o),
    .rdata_o     (rdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("timeout: the run went past %0d cycles, done_o never arrived", CYCLE_LIMIT);
      $display("** FAIL **");
      $fatal(1, "simulation timed out");
    end
  end

  function automatic logic [63:0] xorshift64(input logic [63:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 7);
    s = s ^ (s << 17);
    return s;
  endfunction

  function automatic int op_bytes(input lsu_pkg::mem_op_e op);
    case (op)
      lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_SB: return 1;
      lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: return 2;
      lsu_pkg::OP_LW, lsu_pkg::OP_LWU, lsu_pkg::OP_SW: return 4;
      default:                                         return 8;
    endcase
  endfunction

  function automatic logic is_store(input lsu_pkg::mem_op_e op);
    return op inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW, lsu_pkg::OP_SD};
  endfunction

  // depends on every address bit
  function automatic logic [63:0] fill_word(input logic [63:0] a);
    return (a * 64'h9e37_79b9_7f4a_7c15) ^ 64'h5a5a_0f0f_c3c3_9696;
  endfunction

  function automatic void store_shadow(input lsu_pkg::mem_op_e op, input logic [63:0] addr,
                                       input logic [63:0] wdata);
    int n;
    int off;
    n   = op_bytes(op);
    off = int'(addr[2:0]);
    for (int i = 0; i < n; i++) begin
      shadow[addr[10:3]][8*(off+i) +: 8] = wdata[8*i +: 8];
    end
  endfunction

  function automatic logic [63:0] predict_load(input lsu_pkg::mem_op_e op,
                                               input logic [63:0] addr);
    logic [63:0] w;
    logic [63:0] v;
    int          n;
    w = shadow[addr[10:3]];
    n = op_bytes(op);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = w[8*(int'(addr[2:0])+i) +: 8];
    end
    if (op inside {lsu_pkg::OP_LB, lsu_pkg::OP_LH, lsu_pkg::OP_LW} && v[8*n-1]) begin
      for (int b = 8*n; b < 64; b++) begin
        v[b] = 1'b1;  // sign fill
      end
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("error: time %0t, %s expected %h, got %h", $time, name, exp, act);
      $display("** FAIL **");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // one request from drive to done, then the cycle where busy falls
  task automatic run_access(input lsu_pkg::mem_op_e op, input logic [63:0] addr,
                            input logic [63:0] wdata);
    logic [63:0] exp_data;
    logic        aligned;
    aligned  = ((addr[2:0] & 3'(op_bytes(op) - 1)) == 3'd0);
    exp_data = last_rdata;
    if (aligned && !is_store(op)) begin
      exp_data = predict_load(op, addr);
    end
    req_i.op    = op;
    req_i.addr  = addr;
    req_i.wdata = wdata;
    req_valid_i = 1'b1;
    @(posedge clk);
    #2 req_valid_i = 1'b0;
    while (done_o !== 1'b1) begin
      check_value("busy_o", 64'd1, 64'(busy_o));
      @(posedge clk);
      #2;
    end
    check_value("busy_o", 64'd1, 64'(busy_o));
    check_value("err_o", 64'(!aligned), 64'(err_o));
    check_value("rdata_o", exp_data, rdata_o);
    last_rdata = exp_data;
    if (aligned && is_store(op)) begin
      store_shadow(op, addr, wdata);
    end
    @(posedge clk);
    #2;
    check_value("busy_o", 64'd0, 64'(busy_o));
    check_value("done_o", 64'd0, 64'(done_o));
  endtask

  task automatic reset_and_double();
    logic [63:0] a;
    check_value("busy_o", 64'd0, 64'(busy_o));
    check_value("done_o", 64'd0, 64'(done_o));
    check_value("err_o", 64'd0, 64'(err_o));
    check_value("rdata_o", 64'd0, rdata_o);
    rng = xorshift64(rng);
    a   = rng & ~64'h7;
    run_access(lsu_pkg::OP_SD, a, 64'h0123_4567_89ab_cdef);
    run_access(lsu_pkg::OP_LD, a, 64'd0);
  endtask

  task automatic fill_memory();
    logic [63:0] a;
    for (int i = 0; i < N_FILL; i++) begin
      a = 64'(i) << 3;
      run_access(lsu_pkg::OP_SD, a, fill_word(a));
    end
  endtask

  task automatic partial_stores();
    lsu_pkg::mem_op_e op;
    logic [63:0]      base;
    for (int k = 0; k < 3; k++) begin
      op   = (k == 0) ? lsu_pkg::OP_SB : (k == 1) ? lsu_pkg::OP_SH : lsu_pkg::OP_SW;
      rng  = xorshift64(rng);
      base = rng & ~64'h7;
      for (int off = 0; off < 8; off += op_bytes(op)) begin
        rng = xorshift64(rng);
        run_access(op, base + 64'(off), rng);
        run_access(lsu_pkg::OP_LD, base, 64'd0);
      end
    end
  endtask

  task automatic sign_extension();
    lsu_pkg::mem_op_e op;
    logic [63:0]      base;
    logic [63:0]      pats [2];
    pats[0] = 64'h8f9e_adbc_cbda_e9f8;  // every byte negative
    pats[1] = 64'h0f1e_2d3c_4b5a_6978;
    for (int p = 0; p < 2; p++) begin
      rng  = xorshift64(rng);
      base = rng & ~64'h7;
      run_access(lsu_pkg::OP_SD, base, pats[p]);
      for (int k = 0; k < 7; k++) begin
        op = lsu_pkg::mem_op_e'(4'(k));
        if (op == lsu_pkg::OP_LD) continue;
        for (int off = 0; off < 8; off += op_bytes(op)) begin
          run_access(op, base + 64'(off), 64'd0);
        end
      end
    end
  endtask

  task automatic misaligned_accesses();
    lsu_pkg::mem_op_e op;
    logic [63:0]      base;
    rng  = xorshift64(rng);
    base = rng & ~64'h7;
    for (int k = 0; k < 11; k++) begin
      op = lsu_pkg::mem_op_e'(4'(k));
      if (op_bytes(op) == 1) continue;
      for (int off = 1; off < 8; off++) begin
        if (off % op_bytes(op) != 0) begin
          rng = xorshift64(rng);
          run_access(op, base + 64'(off), rng);
        end
      end
    end
    run_access(lsu_pkg::OP_LD, base, 64'd0);  // memory must be untouched
  endtask

  task automatic random_traffic();
    lsu_pkg::mem_op_e op;
    logic [63:0]      a;
    for (int i = 0; i < N_RANDOM; i++) begin
      rng = xorshift64(rng);
      op  = lsu_pkg::mem_op_e'(4'(rng % 11));
      rng = xorshift64(rng);
      a   = rng & ~(64'(op_bytes(op)) - 64'd1);
      rng = xorshift64(rng);
      run_access(op, a, rng);
    end
  endtask

  initial begin
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rng         = 64'd6;
    last_rdata  = '0;
    repeat (5) @(posedge clk);
    #2 arst_n_i = 1'b1;
    reset_and_double();
    fill_memory();
    partial_stores();
    sign_extension();
    misaligned_accesses();
    random_traffic();
    if (dut.u_master.u_bus_checks.fail_cnt == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("bus protocol assertions failed %0d times", dut.u_master.u_bus_checks.fail_cnt);
      $display("** FAIL **");
      $fatal(1, "bus protocol violations");
    end
  end

endmodule

/* lsu_assertions.sv */
// bus master handshake rules; checks are off while arst_n_i is low
module lsu_assertions (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             aw_valid_i,
  input  logic             aw_ready_i,
  input  lsu_pkg::wr_req_t aw_i,
  input  logic             ar_valid_i,
  input  logic             ar_ready_i,
  input  lsu_pkg::rd_req_t ar_i,
  input  logic             b_ready_i,
  input  logic             r_ready_i
);

  int fail_cnt = 0;

  // valid holds with its payload until ready
  aw_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
    else begin
      $error("write address valid dropped or payload changed before ready");
      fail_cnt++;
    end

  ar_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
    else begin
      $error("read address valid dropped or payload changed before ready");
      fail_cnt++;
    end

  one_addr: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(aw_valid_i && ar_valid_i))
    else begin
      $error("write and read address valid high together");
      fail_cnt++;
    end

  one_resp: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(b_ready_i && r_ready_i))  // single outstanding access
    else begin
      $error("write response and read data ready high together");
      fail_cnt++;
    end

endmodule

bind lsu_bus_master lsu_assertions u_bus_checks (
  .clk        (clk),
  .arst_n_i   (arst_n_i),
  .aw_valid_i (aw_valid_o),
  .aw_ready_i (aw_ready_i),
  .aw_i       (aw_o),
  .ar_valid_i (ar_valid_o),
  .ar_ready_i (ar_ready_i),
  .ar_i       (ar_o),
  .b_ready_i  (b_ready_o),
  .r_ready_i  (r_ready_o)
);

/* lsu_top.sv */
// no back-pressure on req_valid_i; wait for done_o before the next request
module lsu_top (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  logic                     req_valid_i,
  input  lsu_pkg::mem_req_t        req_i,
  output logic                     busy_o,
  output logic                     done_o,
  output logic                     err_o,
  output logic [lsu_pkg::XLEN-1:0] rdata_o
);

  logic                     wr_strobe;
  logic                     rd_strobe;
  logic                     misalign;
  lsu_pkg::wr_req_t         wr_req;
  lsu_pkg::rd_req_t         rd_req;
  lsu_pkg::load_ctl_t       ctl;
  lsu_pkg::wr_req_t         aw;
  lsu_pkg::rd_req_t         ar;
  logic                     aw_valid;
  logic                     aw_ready;
  logic                     b_valid;
  logic                     b_ready;
  logic                     ar_valid;
  logic                     ar_ready;
  logic                     r_valid;
  logic                     r_ready;
  logic [lsu_pkg::XLEN-1:0] r_data;
  logic                     wr_done;
  logic                     rd_done;
  logic [lsu_pkg::XLEN-1:0] rd_data;

  lsu_req_align u_align (
    .clk, .arst_n_i, .req_valid_i, .req_i,
    .done_i      (done_o),        // clears busy
    .busy_o,
    .wr_strobe_o (wr_strobe),
    .rd_strobe_o (rd_strobe),
    .misalign_o  (misalign),
    .wr_req_o    (wr_req),
    .rd_req_o    (rd_req),
    .ctl_o       (ctl)
  );

  lsu_bus_master u_master (
    .clk, .arst_n_i,
    .wr_strobe_i (wr_strobe), .rd_strobe_i (rd_strobe),
    .wr_req_i    (wr_req),    .rd_req_i    (rd_req),
    .aw_valid_o  (aw_valid),  .aw_o        (aw),       .aw_ready_i (aw_ready),
    .b_valid_i   (b_valid),   .b_ready_o   (b_ready),
    .ar_valid_o  (ar_valid),  .ar_o        (ar),       .ar_ready_i (ar_ready),
    .r_valid_i   (r_valid),   .r_data_i    (r_data),   .r_ready_o  (r_ready),
    .wr_done_o   (wr_done),   .rd_done_o   (rd_done),  .rd_data_o  (rd_data)
  );

  lsu_load_extend u_extend (
    .clk, .arst_n_i,
    .ctl_i      (ctl),
    .misalign_i (misalign),
    .wr_done_i  (wr_done),
    .rd_done_i  (rd_done),
    .rd_data_i  (rd_data),
    .done_o, .err_o, .rdata_o
  );

  lsu_data_ram u_ram (
    .clk, .arst_n_i,
    .aw_valid_i (aw_valid), .aw_i (aw), .aw_ready_o (aw_ready),
    .b_valid_o  (b_valid),  .b_ready_i  (b_ready),
    .ar_valid_i (ar_valid), .ar_i (ar), .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),  .r_data_o   (r_data),   .r_ready_i (r_ready)
  );

endmodule

/* lsu_data_ram.sv */
// RAM_WORDS doublewords, contents not reset; address bits above RAM_IDX_W+2 are ignored
module lsu_data_ram (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  logic                     aw_valid_i,
  input  lsu_pkg::wr_req_t         aw_i,
  output logic                     aw_ready_o,
  output logic                     b_valid_o,
  input  logic                     b_ready_i,
  input  logic                     ar_valid_i,
  input  lsu_pkg::rd_req_t         ar_i,
  output logic                     ar_ready_o,
  output logic                     r_valid_o,
  output logic [lsu_pkg::XLEN-1:0] r_data_o,
  input  logic                     r_ready_i
);

  logic [lsu_pkg::XLEN-1:0]      mem [lsu_pkg::RAM_WORDS];
  logic [lsu_pkg::RAM_IDX_W-1:0] w_idx;
  logic [lsu_pkg::RAM_IDX_W-1:0] r_idx;
  logic                          aw_fire;
  logic                          ar_fire;

  assign w_idx   = aw_i.addr[lsu_pkg::RAM_IDX_W+lsu_pkg::OFF_W-1:lsu_pkg::OFF_W];
  assign r_idx   = ar_i.addr[lsu_pkg::RAM_IDX_W+lsu_pkg::OFF_W-1:lsu_pkg::OFF_W];
  assign aw_fire = aw_valid_i && aw_ready_o;
  assign ar_fire = ar_valid_i && ar_ready_o;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_ready_o <= 1'b0;
      ar_ready_o <= 1'b0;
      b_valid_o  <= 1'b0;
      r_valid_o  <= 1'b0;
    end else begin
      // one wait state, and no new address while a response is pending
      aw_ready_o <= aw_valid_i && !aw_ready_o && !b_valid_o;
      ar_ready_o <= ar_valid_i && !ar_ready_o && !r_valid_o;
      if (aw_fire) begin
        b_valid_o <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_o <= 1'b0;
      end
      if (ar_fire) begin
        r_valid_o <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      for (int i = 0; i < lsu_pkg::LANES; i++) begin
        if (aw_i.strb[i]) begin
          mem[w_idx][8*i +: 8] <= aw_i.data[8*i +: 8];
        end
      end
    end
    if (ar_fire) begin
      r_data_o <= mem[r_idx];  // held until the next read
    end
  end

endmodule

/* lsu_load_extend.sv */
// ctl_i must stay stable from the read strobe until rd_done_i; rdata_o keeps its value on writes
module lsu_load_extend (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  lsu_pkg::load_ctl_t       ctl_i,
  input  logic                     misalign_i,
  input  logic                     wr_done_i,
  input  logic                     rd_done_i,
  input  logic [lsu_pkg::XLEN-1:0] rd_data_i,
  output logic                     done_o,
  output logic                     err_o,
  output logic [lsu_pkg::XLEN-1:0] rdata_o
);

  logic [lsu_pkg::XLEN-1:0] shifted;
  logic [lsu_pkg::XLEN-1:0] ext;

  assign shifted = rd_data_i >> {ctl_i.off, 3'b000};  // addressed byte to lane 0

  always_comb begin
    case (ctl_i.op)
      lsu_pkg::OP_LB:  ext = {{56{shifted[7]}}, shifted[7:0]};
      lsu_pkg::OP_LH:  ext = {{48{shifted[15]}}, shifted[15:0]};
      lsu_pkg::OP_LW:  ext = {{32{shifted[31]}}, shifted[31:0]};
      lsu_pkg::OP_LBU: ext = {56'd0, shifted[7:0]};
      lsu_pkg::OP_LHU: ext = {48'd0, shifted[15:0]};
      lsu_pkg::OP_LWU: ext = {32'd0, shifted[31:0]};
      default:         ext = shifted;  // OP_LD
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_o  <= 1'b0;
      err_o   <= 1'b0;
      rdata_o <= '0;
    end else begin
      done_o <= wr_done_i || rd_done_i || misalign_i;
      err_o  <= misalign_i;
      if (rd_done_i) begin
        rdata_o <= ext;
      end
    end
  end

endmodule

/* lsu_bus_master.sv */
// single outstanding access, no bursts; strobes arriving while not idle are ignored
module lsu_bus_master (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  logic                     wr_strobe_i,
  input  logic                     rd_strobe_i,
  input  lsu_pkg::wr_req_t         wr_req_i,
  input  lsu_pkg::rd_req_t         rd_req_i,
  // write address/data and response
  output logic                     aw_valid_o,
  output lsu_pkg::wr_req_t         aw_o,
  input  logic                     aw_ready_i,
  input  logic                     b_valid_i,
  output logic                     b_ready_o,
  // read address and data
  output logic                     ar_valid_o,
  output lsu_pkg::rd_req_t         ar_o,
  input  logic                     ar_ready_i,
  input  logic                     r_valid_i,
  input  logic [lsu_pkg::XLEN-1:0] r_data_i,
  output logic                     r_ready_o,
  // completion to the output side
  output logic                     wr_done_o,
  output logic                     rd_done_o,
  output logic [lsu_pkg::XLEN-1:0] rd_data_o
);

  lsu_pkg::bus_state_e state;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state      <= lsu_pkg::ST_IDLE;
      aw_valid_o <= 1'b0;
      ar_valid_o <= 1'b0;
      b_ready_o  <= 1'b0;
      r_ready_o  <= 1'b0;
      wr_done_o  <= 1'b0;
      rd_done_o  <= 1'b0;
    end else begin
      wr_done_o <= 1'b0;  // single-cycle strobes
      rd_done_o <= 1'b0;
      case (state)
        lsu_pkg::ST_IDLE: begin
          if (wr_strobe_i) begin
            aw_valid_o <= 1'b1;
            state      <= lsu_pkg::ST_WADDR;
          end else if (rd_strobe_i) begin
            ar_valid_o <= 1'b1;
            state      <= lsu_pkg::ST_RADDR;
          end
        end
        lsu_pkg::ST_WADDR: begin
          if (aw_ready_i) begin  // address taken, wait for response
            aw_valid_o <= 1'b0;
            b_ready_o  <= 1'b1;
            state      <= lsu_pkg::ST_WRESP;
          end
        end
        lsu_pkg::ST_WRESP: begin
          if (b_valid_i) begin
            b_ready_o <= 1'b0;
            wr_done_o <= 1'b1;
            state     <= lsu_pkg::ST_IDLE;
          end
        end
        lsu_pkg::ST_RADDR: begin
          if (ar_ready_i) begin
            ar_valid_o <= 1'b0;
            r_ready_o  <= 1'b1;
            state      <= lsu_pkg::ST_RDATA;
          end
        end
        lsu_pkg::ST_RDATA: begin
          if (r_valid_i) begin
            r_ready_o <= 1'b0;
            rd_done_o <= 1'b1;
            state     <= lsu_pkg::ST_IDLE;
          end
        end
        default: begin
          aw_valid_o <= 1'b0;
          ar_valid_o <= 1'b0;
          b_ready_o  <= 1'b0;
          r_ready_o  <= 1'b0;
          state      <= lsu_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // payload only loads from idle, so it stays put while valid is up
  always_ff @(posedge clk) begin
    if (state == lsu_pkg::ST_IDLE) begin
      if (wr_strobe_i) begin
        aw_o <= wr_req_i;
      end
      if (rd_strobe_i) begin
        ar_o <= rd_req_i;
      end
    end
    if (state == lsu_pkg::ST_RDATA && r_valid_i) begin
      rd_data_o <= r_data_i;
    end
  end

endmodule

/* lsu_req_align.sv */
// one request at a time; a request while busy_o is high is dropped, misaligned ones make no bus access
module lsu_req_align (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               req_valid_i,
  input  lsu_pkg::mem_req_t  req_i,
  input  logic               done_i,
  output logic               busy_o,
  output logic               wr_strobe_o,
  output logic               rd_strobe_o,
  output logic               misalign_o,
  output lsu_pkg::wr_req_t   wr_req_o,
  output lsu_pkg::rd_req_t   rd_req_o,
  output lsu_pkg::load_ctl_t ctl_o
);

  logic                      accept;
  logic                      is_store;
  logic [1:0]                size;        // log2 of bytes
  logic [lsu_pkg::OFF_W-1:0] off;
  logic [lsu_pkg::OFF_W-1:0] size_mask;
  logic [lsu_pkg::LANES-1:0] strb_base;
  logic                      misaligned;

  assign accept     = req_valid_i && !busy_o;
  assign off        = req_i.addr[lsu_pkg::OFF_W-1:0];
  assign misaligned = |(off & size_mask);

  always_comb begin
    is_store = 1'b0;
    size     = 2'd3;
    case (req_i.op)
      lsu_pkg::OP_LB, lsu_pkg::OP_LBU: size = 2'd0;
      lsu_pkg::OP_LH, lsu_pkg::OP_LHU: size = 2'd1;
      lsu_pkg::OP_LW, lsu_pkg::OP_LWU: size = 2'd2;
      lsu_pkg::OP_SB: begin
        is_store = 1'b1;
        size     = 2'd0;
      end
      lsu_pkg::OP_SH: begin
        is_store = 1'b1;
        size     = 2'd1;
      end
      lsu_pkg::OP_SW: begin
        is_store = 1'b1;
        size     = 2'd2;
      end
      lsu_pkg::OP_SD: is_store = 1'b1;
      default:        size = 2'd3;   // OP_LD
    endcase
  end

  // natural alignment mask and unshifted lane strobes
  always_comb begin
    case (size)
      2'd0:    {size_mask, strb_base} = {3'b000, 8'h01};
      2'd1:    {size_mask, strb_base} = {3'b001, 8'h03};
      2'd2:    {size_mask, strb_base} = {3'b011, 8'h0f};
      default: {size_mask, strb_base} = {3'b111, 8'hff};
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_o      <= 1'b0;
      wr_strobe_o <= 1'b0;
      rd_strobe_o <= 1'b0;
      misalign_o  <= 1'b0;
    end else begin
      wr_strobe_o <= accept && is_store && !misaligned;
      rd_strobe_o <= accept && !is_store && !misaligned;
      misalign_o  <= accept && misaligned;
      if (accept) begin
        busy_o <= 1'b1;
      end else if (done_i) begin
        busy_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_req_o.addr <= req_i.addr;
      wr_req_o.data <= req_i.wdata << {off, 3'b000};  // move to byte lane
      wr_req_o.strb <= strb_base << off;
      rd_req_o.addr <= req_i.addr;
      ctl_o.op      <= req_i.op;
      ctl_o.off     <= off;
    end
  end

endmodule

/* lsu_pkg.sv */
// shared types for the load/store unit; little-endian lanes, RAM index wraps above bit RAM_IDX_W+2
package lsu_pkg;

  localparam int XLEN      = 64;
  localparam int ADDR_W    = 64;
  localparam int LANES     = XLEN / 8;
  localparam int OFF_W     = $clog2(LANES);  // byte offset inside a doubleword
  localparam int RAM_WORDS = 256;
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);

  // loads first, stores after
  typedef enum logic [3:0] {
    OP_LB  = 4'd0,
    OP_LH  = 4'd1,
    OP_LW  = 4'd2,
    OP_LD  = 4'd3,
    OP_LBU = 4'd4,
    OP_LHU = 4'd5,
    OP_LWU = 4'd6,
    OP_SB  = 4'd7,
    OP_SH  = 4'd8,
    OP_SW  = 4'd9,
    OP_SD  = 4'd10
  } mem_op_e;

  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_WADDR = 3'd1,
    ST_WRESP = 3'd2,
    ST_RADDR = 3'd3,
    ST_RDATA = 3'd4
  } bus_state_e;

  // request from the pipeline
  typedef struct packed {
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   wdata;
  } mem_req_t;

  // write with data already on its lanes
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   data;
    logic [LANES-1:0]  strb;
  } wr_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } rd_req_t;

  // what the output side needs to pick and extend the loaded lanes
  typedef struct packed {
    mem_op_e          op;
    logic [OFF_W-1:0] off;
  } load_ctl_t;

endpackage
